/* Bender.yml */
package:
  name: apb_delay

dependencies: {}

sources:
  # Packages and the interface come before the modules that use them
  - design/apb_pkg.sv
  - design/delay_pkg.sv
  - design/apb_if.sv
  - design/apb_delayer.sv
  - design/apb_scratch_memory.sv
  - design/apb_delay_top.sv

  # Testbench with bound assertions, top module apb_delay_tb
  - target: simulation
    files:
      - bench/apb_delay_assertions.sv
      - bench/apb_delay_checker.sv
      - bench/apb_delay_tb.sv

/* bench/apb_delay_assertions.sv */
module apb_delay_assertions (
  input logic               clock,
  input logic               reset,
  input apb_pkg::apb_addr_t paddr,
  input logic               psel,
  input logic               penable,
  input logic               pwrite,
  input apb_pkg::apb_data_t pwdata,
  input apb_pkg::apb_strb_t pstrb,
  input logic               req_pready,
  input logic               dev_pready
);

  logic dev_done;  // Device already answered the open transfer

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      dev_done <= 1'b0;
    end else if (!psel) begin
      dev_done <= 1'b0;
    end else if (dev_pready) begin
      dev_done <= 1'b1;
    end
  end

  // Requester sees pready only in an access phase, after the device answered
  assert property (@(posedge clock) disable iff (reset)
    req_pready |-> (psel && penable && dev_done))
    else $error("Requester pready outside an access phase or ahead of the device");

  // Access phase stays open and unchanged until the completion
  assert property (@(posedge clock) disable iff (reset)
    (psel && penable && !req_pready) |=>
      (psel && penable && $stable(paddr) && $stable(pwrite) &&
       $stable(pwdata) && $stable(pstrb)))
    else $error("Request changed or dropped before pready");

  assert property (@(posedge clock) disable iff (reset)
    dev_done |-> !dev_pready)  // One completion from the memory per transfer
    else $error("Device pready high more than once in a transfer");

endmodule

bind apb_delayer apb_delay_assertions i_apb_delay_assertions (
  .clock      (clock),
  .reset      (reset),
  .paddr      (upstream.paddr),
  .psel       (upstream.psel),
  .penable    (upstream.penable),
  .pwrite     (upstream.pwrite),
  .pwdata     (upstream.pwdata),
  .pstrb      (upstream.pstrb),
  .req_pready (upstream.pready),
  .dev_pready (downstream.pready)
);

/* bench/apb_delay_checker.sv */
module apb_delay_checker (
  input  logic               clock,
  input  logic               reset,
  input  apb_pkg::apb_addr_t paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  apb_pkg::apb_data_t pwdata,
  input  apb_pkg::apb_strb_t pstrb,
  input  logic               pready,
  input  apb_pkg::apb_data_t prdata,
  input  logic               pslverr,
  output int unsigned        error_count,
  output int unsigned        completed
);
  import apb_pkg::*;
  import delay_pkg::*;

  apb_data_t model [mem_words];  // Reference copy of the scratch memory

  int unsigned errors       = 0;
  int unsigned passes       = 0;
  int unsigned transfers    = 0;
  int unsigned reset_edges  = 0;
  int unsigned cycles       = 0;  // Edges since the first access-phase edge
  logic        reset_done   = 1'b0;
  logic        in_access    = 1'b0;

  apb_addr_t cap_addr;
  logic      cap_write;
  apb_data_t cap_wdata;
  apb_strb_t cap_strb;

  assign error_count = errors;
  assign completed   = transfers;

  initial begin
    for (int i = 0; i < mem_words; i++) begin
      model[i] = '0;
    end
  end

  // Device wait states plus the 5.5x stretch, rounded down, plus two cycles
  function automatic int unsigned expected_latency(input int unsigned w);
    return w + (w * stretch_ratio_num) / stretch_ratio_den + 2;
  endfunction

  function automatic apb_data_t apply_strobes(input apb_data_t old, input apb_data_t data,
                                              input apb_strb_t strb);
    apb_data_t result;
    result = old;
    for (int b = 0; b < strb_width; b++) begin
      if (strb[b]) result[8*b +: 8] = data[8*b +: 8];
    end
    return result;
  endfunction

  function automatic bit value_differs(input string name, input string field,
                                       input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected 0x%0h actual 0x%0h", name, field, expected, actual);
      return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic check_reset_state(input string name);
    bit bad;
    bad = value_differs(name, "pready", 32'd0, {31'd0, pready}) |
          value_differs(name, "pslverr", 32'd0, {31'd0, pslverr}) |
          value_differs(name, "prdata", 32'd0, prdata);
    if (bad) errors++;
    else begin
      passes++;
      $display("PASS %s", name);
    end
  endtask

  task automatic finish_transfer();
    string       name;
    int unsigned word;
    int unsigned w;
    logic        in_range;
    bit          bad;
    word     = int'(cap_addr >> 2);
    w        = cap_addr[3:2];
    in_range = (word < mem_words);
    name     = $sformatf("xfer%0d_%s_idx%0d", transfers, cap_write ? "write" : "read", word);
    bad      = value_differs(name, "latency", expected_latency(w), cycles);
    bad      = value_differs(name, "pslverr", {31'd0, !in_range}, {31'd0, pslverr}) | bad;
    if (!in_range) begin
      bad = value_differs(name, "prdata", 32'd0, prdata) | bad;
    end else if (!cap_write) begin
      bad = value_differs(name, "prdata", model[word], prdata) | bad;
    end else begin
      model[word] = apply_strobes(model[word], cap_wdata, cap_strb);
    end
    transfers++;
    if (bad) errors++;
    else begin
      passes++;
      $display("PASS %s latency %0d", name, cycles);
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d tests, %0d passed, %0d failed", passes + errors, passes, errors);
  endtask

  always @(posedge clock) begin
    if (reset) begin
      // First edge is skipped, registers settle on it
      if (reset_edges > 0) check_reset_state("reset_during");
      reset_edges++;
    end else begin
      if (!reset_done) begin
        check_reset_state("reset_after");
        reset_done = 1'b1;
      end
      if (psel && penable) begin
        if (!in_access) begin
          cap_addr  = paddr;
          cap_write = pwrite;
          cap_wdata = pwdata;
          cap_strb  = pstrb;
          cycles    = 0;
          in_access = 1'b1;
        end else begin
          cycles++;
        end
        if (pready) begin
          finish_transfer();
          in_access = 1'b0;
        end
      end else if (pready) begin
        $display("Error: pready high while no access phase is open");
        errors++;
      end
    end
  end

endmodule

/* bench/apb_delay_tb.sv */
module apb_delay_tb;
  import apb_pkg::*;

  localparam int unsigned transfer_count = 300;
  localparam int unsigned ready_timeout  = 60;  // Cycles allowed per access phase

  logic      clock;
  logic      reset;
  apb_addr_t paddr;
  logic      psel;
  logic      penable;
  apb_prot_t pprot;
  logic      pwrite;
  apb_data_t pwdata;
  apb_strb_t pstrb;
  logic      pready;
  apb_data_t prdata;
  logic      pslverr;

  int unsigned error_count;
  int unsigned completed;
  logic        timed_out;

  apb_delay_top i_apb_delay_top (
    .clock   (clock),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pprot   (pprot),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .pready  (pready),
    .prdata  (prdata),
    .pslverr (pslverr)
  );

  apb_delay_checker i_apb_delay_checker (
    .clock       (clock),
    .reset       (reset),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .pstrb       (pstrb),
    .pready      (pready),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .error_count (error_count),
    .completed   (completed)
  );

  always #2 clock = ~clock;

  // Setup, access, then wait for pready; called 1 unit after a rising edge
  task automatic run_transfer(input apb_addr_t addr, input logic write,
                              input apb_data_t data, input apb_strb_t strb);
    int unsigned waited;
    paddr   = addr;
    pwrite  = write;
    pwdata  = data;
    pstrb   = strb;
    pprot   = apb_prot_t'($urandom);
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clock);
    #1 penable = 1'b1;
    waited = 0;
    do begin
      @(posedge clock);
      waited++;
    end while (!pready && waited < ready_timeout);
    if (!pready) begin
      timed_out = 1'b1;
      $display("Timeout: pready stayed low for %0d cycles at address 0x%08h", waited, addr);
    end
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic run_random_transfers(input int unsigned count);
    int unsigned index;
    int unsigned gap;
    for (int unsigned n = 0; n < count && !timed_out; n++) begin
      index = $urandom_range(19, 0);  // 16 to 19 fall outside the memory
      run_transfer(apb_addr_t'(index) << 2, logic'($urandom_range(1, 0)),
                   apb_data_t'($urandom), apb_strb_t'($urandom));
      gap = $urandom_range(3, 0);
      repeat (gap + 1) @(posedge clock);  // One idle cycle is always needed
      #1;
    end
  endtask

  initial begin
    void'($urandom(28913));
    clock     = 1'b0;
    reset     = 1'b1;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pprot     = '0;
    pwrite    = 1'b0;
    pwdata    = '0;
    pstrb     = '0;
    timed_out = 1'b0;

    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
    repeat (2) @(posedge clock);
    #1;

    run_random_transfers(transfer_count);
    repeat (2) @(posedge clock);

    if (!timed_out && completed != transfer_count) begin
      $display("MISMATCH transfer_count expected %0d actual %0d", transfer_count, completed);
    end
    i_apb_delay_checker.print_summary();
    if (error_count == 0 && !timed_out && completed == transfer_count) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* design/apb_delay_top.sv */
module apb_delay_top (
  input  logic               clock,
  input  logic               reset,

  // Requester side
  input  apb_pkg::apb_addr_t paddr,
  input  logic               psel,
  input  logic               penable,
  input  apb_pkg::apb_prot_t pprot,
  input  logic               pwrite,
  input  apb_pkg::apb_data_t pwdata,
  input  apb_pkg::apb_strb_t pstrb,
  output logic               pready,
  output apb_pkg::apb_data_t prdata,
  output logic               pslverr
);

  apb_if req_bus (
    .clock (clock),
    .reset (reset)
  );

  apb_if dev_bus (
    .clock (clock),
    .reset (reset)
  );

  // Plain ports onto the requester-side bus
  assign req_bus.paddr   = paddr;
  assign req_bus.psel    = psel;
  assign req_bus.penable = penable;
  assign req_bus.pprot   = pprot;
  assign req_bus.pwrite  = pwrite;
  assign req_bus.pwdata  = pwdata;
  assign req_bus.pstrb   = pstrb;

  assign pready  = req_bus.pready;
  assign prdata  = req_bus.prdata;
  assign pslverr = req_bus.pslverr;

  // Stretch stage between requester and memory
  apb_delayer i_apb_delayer (
    .clock      (clock),
    .reset      (reset),
    .upstream   (req_bus.completer),
    .downstream (dev_bus.requester)
  );

  apb_scratch_memory i_apb_scratch_memory (
    .clock (clock),
    .reset (reset),
    .bus   (dev_bus.completer)
  );

endmodule

/* design/apb_delayer.sv */
module apb_delayer (
  input logic      clock,
  input logic      reset,
  apb_if.completer upstream,
  apb_if.requester downstream
);
  import apb_pkg::*;
  import delay_pkg::*;

  typedef enum logic [1:0] {
    idle,
    wait_device,
    delay
  } state_t;

  state_t state;

  logic [acc_width-1:0]         acc;         // Scaled count of device wait cycles
  logic [delay_count_width-1:0] acc_cycles;  // Accumulator converted back to cycles
  logic [delay_count_width-1:0] delay_count;

  // Captured response, presented upstream after the stretch
  logic      resp_ready;
  apb_data_t resp_rdata;
  logic      resp_slverr;

  logic access;
  logic released;

  // Request path is a straight pass-through
  assign downstream.paddr   = upstream.paddr;
  assign downstream.psel    = upstream.psel;
  assign downstream.penable = upstream.penable;
  assign downstream.pprot   = upstream.pprot;
  assign downstream.pwrite  = upstream.pwrite;
  assign downstream.pwdata  = upstream.pwdata;
  assign downstream.pstrb   = upstream.pstrb;

  assign access   = upstream.psel && upstream.penable;
  assign released = !upstream.psel && !upstream.penable;

  // Divide by the fixed-point scale
  assign acc_cycles = acc[stretch_shift +: delay_count_width];

  // Only answer while the access phase is still open
  assign upstream.pready  = resp_ready && access;
  assign upstream.prdata  = resp_rdata;
  assign upstream.pslverr = resp_slverr;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state       <= idle;
      acc         <= '0;
      delay_count <= '0;
      resp_ready  <= 1'b0;
      resp_rdata  <= '0;
      resp_slverr <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (access) begin
            // First access cycle already counts when the device is waiting
            if (downstream.pready) begin
              resp_rdata  <= downstream.prdata;
              resp_slverr <= downstream.pslverr;
              delay_count <= acc_cycles; // Zero, nothing accumulated yet
              state       <= delay;
            end else begin
              acc   <= acc + acc_width'(stretch_scaled);
              state <= wait_device;
            end
          end
        end

        wait_device: begin
          if (!downstream.pready) begin
            acc <= acc + acc_width'(stretch_scaled);
          end else begin
            resp_rdata  <= downstream.prdata;    // Device answers for one cycle only
            resp_slverr <= downstream.pslverr;
            delay_count <= acc_cycles;
            state       <= delay;
          end
        end

        delay: begin
          if (delay_count != '0) begin
            delay_count <= delay_count - 1'b1;
          end else if (resp_ready && released) begin
            // Requester has closed the transfer
            resp_ready <= 1'b0;
            acc        <= '0;
            state      <= idle;
          end else begin
            resp_ready <= 1'b1; // Held until psel and penable drop
          end
        end

        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

/* design/apb_if.sv */
interface apb_if (
  input logic clock,
  input logic reset
);
  import apb_pkg::*;

  apb_addr_t paddr;
  logic      psel;
  logic      penable;
  apb_prot_t pprot;
  logic      pwrite;
  apb_data_t pwdata;
  apb_strb_t pstrb;

  // Completer response
  logic      pready;
  apb_data_t prdata;
  logic      pslverr;

  // Side that issues transfers
  modport requester (
    input  clock, reset,
    output paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
    input  pready, prdata, pslverr
  );

  // Side that answers transfers
  modport completer (
    input  clock, reset,
    input  paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
    output pready, prdata, pslverr
  );

endinterface

/* design/apb_pkg.sv */
package apb_pkg;

  // Bus geometry
  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;
  localparam int unsigned strb_width = data_width / 8; // One enable per byte lane

  // Protection field is carried along but never decoded
  localparam int unsigned prot_width = 3;

  typedef logic [addr_width-1:0] apb_addr_t;
  typedef logic [data_width-1:0] apb_data_t;
  typedef logic [strb_width-1:0] apb_strb_t;
  typedef logic [prot_width-1:0] apb_prot_t;

  // Scratch memory geometry
  localparam int unsigned mem_words       = 16;
  localparam int unsigned mem_index_width = $clog2(mem_words); // 4 bits of word index

  // Word index starts above the two byte-offset bits, so the index occupies
  // paddr[mem_index_width+1:2] and anything above that must be zero
  // for the access to land inside the memory

endpackage

/* design/apb_scratch_memory.sv */
module apb_scratch_memory (
  input logic      clock,
  input logic      reset,
  apb_if.completer bus
);
  import apb_pkg::*;

  apb_data_t mem [mem_words];

  logic [1:0] wait_count;   // Wait cycles spent in this access
  logic [1:0] wait_target;  // Wait states requested by the address
  logic       done;         // Transfer already answered

  logic                       access;
  logic                       in_range;
  logic                       complete;
  logic [mem_index_width-1:0] word_index;

  assign access      = bus.psel && bus.penable;
  assign wait_target = bus.paddr[3:2];
  assign word_index  = bus.paddr[mem_index_width+1:2];

  // Every address bit above the word index must be clear
  assign in_range = (bus.paddr[addr_width-1:mem_index_width+2] == '0);

  // Exactly one completion cycle per transfer
  assign complete = access && !done && (wait_count == wait_target);

  assign bus.pready  = complete;
  assign bus.pslverr = complete && !in_range;
  assign bus.prdata  = (complete && !bus.pwrite && in_range) ? mem[word_index] : '0;

  // Wait-state counter and done flag
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wait_count <= '0;
      done       <= 1'b0;
    end else if (!bus.psel) begin
      // Transfer closed by the requester
      wait_count <= '0;
      done       <= 1'b0;
    end else if (complete) begin
      wait_count <= '0;
      done       <= 1'b1; // Blocks a second completion during a long hold
    end else if (access && !done) begin
      wait_count <= wait_count + 1'b1;
    end
  end

  // Storage, written only on the completion cycle
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int w = 0; w < mem_words; w++) begin
        mem[w] <= '0;
      end
    end else if (complete && bus.pwrite && in_range) begin
      for (int b = 0; b < strb_width; b++) begin
        if (bus.pstrb[b]) begin
          mem[word_index][8*b +: 8] <= bus.pwdata[8*b +: 8];
        end
      end
    end
  end

endmodule

/* design/delay_pkg.sv */
package delay_pkg;

  // Register widths used by the stretch stage
  localparam int unsigned acc_width         = 32;
  localparam int unsigned delay_count_width = 16;

  // Stretch ratio 5.5 as a fraction
  localparam int unsigned stretch_ratio_num = 11;
  localparam int unsigned stretch_ratio_den = 2;

  // Fixed-point scale is 2**stretch_shift
  localparam int unsigned stretch_shift = 4;

  // Ratio times scale, 11 * 16 / 2 = 88
  localparam int unsigned stretch_scaled =
    stretch_ratio_num * (1 << stretch_shift) / stretch_ratio_den;

  // Each device wait cycle adds stretch_scaled to the accumulator, and the
  // extra hold count is the accumulator shifted right by stretch_shift,
  // which rounds the product down

endpackage

/* filelist.f */
design/apb_pkg.sv
design/delay_pkg.sv
design/apb_if.sv
design/apb_delayer.sv
design/apb_scratch_memory.sv
design/apb_delay_top.sv
bench/apb_delay_assertions.sv
bench/apb_delay_checker.sv
bench/apb_delay_tb.sv
